//--- logic/mmsa_pkg.sv
package mmsa_pkg;

    // --------------------
    // Data widths
    // --------------------

    // One matrix element as it arrives on the stream
    localparam int ELEM_W = 16;

    // Holds the sum of 16 full-range products with headroom
    localparam int ACC_W = 40;

    // --------------------
    // Array and storage
    // --------------------

    // Array side and number of lanes in one stored row
    localparam int LANES = 4;

    // Matrices of each kind per load
    localparam int NUM_MATS  = 16;
    localparam int MAT_IDX_W = 4;

    // One bank row per matrix row and four rows per matrix
    localparam int BANK_DEPTH  = NUM_MATS * LANES;
    localparam int BANK_ADDR_W = $clog2(BANK_DEPTH);

    // Index pairs answered per run
    localparam int NUM_PAIRS = 16;

    // --------------------
    // Types
    // --------------------

    typedef logic signed [ELEM_W-1:0] elem_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // Lane 0 is column 0 and unused lanes stay zero for 2x2
    typedef elem_t [LANES-1:0] row_t;

    typedef enum logic {
        SIZE_2 = 1'b0,
        SIZE_4 = 1'b1
    } mat_size_e;

endpackage

//--- logic/array_feed_if.sv
`timescale 1ns/100ps

interface array_feed_if;
    import mmsa_pkg::*;

    // Row pair moves when valid and ready are both high
    logic valid;
    logic ready;

    // Marks row 0 of a pair
    logic first;

    row_t x_row;
    row_t w_row;

    modport ctrl (
        output valid,
        output first,
        output x_row,
        output w_row,
        input  ready
    );

    modport array (
        input  valid,
        input  first,
        input  x_row,
        input  w_row,
        output ready
    );

endinterface

//--- logic/matrix_bank.sv
`timescale 1ns/100ps

module matrix_bank (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_wr_en,
    input  logic [mmsa_pkg::BANK_ADDR_W-1:0] i_wr_addr,
    input  mmsa_pkg::row_t                   i_wr_row,
    input  logic [mmsa_pkg::BANK_ADDR_W-1:0] i_rd_addr,
    output mmsa_pkg::row_t                   o_rd_row
);
    import mmsa_pkg::*;

    // Matrix m row r lives at address m*4 + r
    row_t mem [BANK_DEPTH];

    // --------------------
    // Write port
    // --------------------

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_row;
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Data follows the address by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_row <= '0;
        end else begin
            o_rd_row <= mem[i_rd_addr];
        end
    end

endmodule

//--- logic/mmsa_ctrl.sv
`timescale 1ns/100ps

module mmsa_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_in_valid,
    input  mmsa_pkg::elem_t                  i_matrix,
    input  mmsa_pkg::mat_size_e              i_matrix_size,
    input  logic                             i_in_valid2,
    input  logic [mmsa_pkg::MAT_IDX_W-1:0]   i_i_mat_idx,
    input  logic [mmsa_pkg::MAT_IDX_W-1:0]   i_w_mat_idx,
    output logic                             o_in_wr_en,
    output logic                             o_wt_wr_en,
    output logic [mmsa_pkg::BANK_ADDR_W-1:0] o_wr_addr,
    output mmsa_pkg::row_t                   o_wr_row,
    output logic [mmsa_pkg::BANK_ADDR_W-1:0] o_in_rd_addr,
    output logic [mmsa_pkg::BANK_ADDR_W-1:0] o_wt_rd_addr,
    input  mmsa_pkg::row_t                   i_in_rd_row,
    input  mmsa_pkg::row_t                   i_wt_rd_row,
    array_feed_if.ctrl                       feed,
    input  mmsa_pkg::acc_t                   i_diag_sum,
    output logic                             o_out_valid,
    output mmsa_pkg::acc_t                   o_out_value
);
    import mmsa_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT,
        ST_FEED,
        ST_DRAIN
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    mat_size_e              size_q;
    mat_size_e              size_cur;
    logic [2:0]             n_cur;
    logic [8:0]             ld_cnt_q;
    logic                   ld_acc;
    logic [1:0]             col;
    logic [1:0]             row;
    logic [MAT_IDX_W-1:0]   mat;
    logic                   is_wt;
    logic                   row_done;
    row_t                   pack_q;
    row_t                   pack_row;
    logic [MAT_IDX_W-1:0]   sel_in_q;
    logic [MAT_IDX_W-1:0]   sel_wt_q;
    logic [4:0]             pair_cnt_q;
    logic [1:0]             rd_cnt_q;
    logic                   rd_en;
    logic                   fv_q;
    logic [1:0]             frow_q;
    logic                   row_live;
    logic                   fire_first;
    logic [3:0]             dcnt_q;
    logic [3:0]             win_last;
    logic                   in_win;

    // --------------------
    // FSM
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (i_in_valid) state_d = ST_LOAD;
            ST_LOAD:  if (!i_in_valid) state_d = ST_WAIT;
            ST_WAIT:  if (i_in_valid2) state_d = ST_FEED;
            ST_FEED:  if (rd_en && rd_cnt_q == 2'd3) state_d = ST_DRAIN;
            ST_DRAIN: begin
                if (dcnt_q == win_last + 4'd1) begin
                    state_d = (pair_cnt_q == NUM_PAIRS) ? ST_IDLE : ST_WAIT;
                end
            end
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Size is taken from the first load element and held for the run
    assign size_cur = (state_q == ST_IDLE) ? i_matrix_size : size_q;
    assign n_cur    = (size_q == SIZE_4) ? 3'(LANES) : 3'(LANES / 2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size_q <= SIZE_2;
        end else if (state_q == ST_IDLE) begin
            size_q <= i_in_valid ? i_matrix_size : SIZE_2;
        end
    end

    // --------------------
    // Load packing
    // --------------------

    assign ld_acc = i_in_valid && (state_q == ST_IDLE || state_q == ST_LOAD);

    // Split the element count into column, row, matrix and kind
    always_comb begin
        if (size_cur == SIZE_4) begin
            col   = ld_cnt_q[1:0];
            row   = ld_cnt_q[3:2];
            mat   = ld_cnt_q[7:4];
            is_wt = ld_cnt_q[8];
        end else begin
            col   = {1'b0, ld_cnt_q[0]};
            row   = {1'b0, ld_cnt_q[1]};
            mat   = ld_cnt_q[5:2];
            is_wt = ld_cnt_q[6];
        end
    end

    assign row_done = (size_cur == SIZE_4) ? (col == 2'd3) : (col == 2'd1);

    // Column 0 starts a fresh row, so 2x2 rows keep lanes 2 and 3 zero
    always_comb begin
        pack_row      = (col == 2'd0) ? '0 : pack_q;
        pack_row[col] = i_matrix;
    end

    always_ff @(posedge clk) begin
        if (ld_acc) begin
            pack_q <= pack_row;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_cnt_q <= '0;
        end else if (ld_acc) begin
            ld_cnt_q <= ld_cnt_q + 9'd1;
        end else if (state_q != ST_LOAD) begin
            ld_cnt_q <= '0;
        end
    end

    assign o_in_wr_en = ld_acc && row_done && !is_wt;
    assign o_wt_wr_en = ld_acc && row_done && is_wt;
    assign o_wr_addr  = {mat, row};
    assign o_wr_row   = pack_row;

    // --------------------
    // Pair select and read
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_in_q   <= '0;
            sel_wt_q   <= '0;
            pair_cnt_q <= '0;
        end else if (state_q == ST_IDLE) begin
            sel_in_q   <= '0;
            sel_wt_q   <= '0;
            pair_cnt_q <= '0;
        end else if (state_q == ST_WAIT && i_in_valid2) begin
            sel_in_q   <= i_i_mat_idx;
            sel_wt_q   <= i_w_mat_idx;
            pair_cnt_q <= pair_cnt_q + 5'd1;
        end
    end

    // Array keeps ready up for all four rows once row 0 has gone in
    assign rd_en        = (state_q == ST_FEED) && feed.ready;
    assign o_in_rd_addr = {sel_in_q, rd_cnt_q};
    assign o_wt_rd_addr = {sel_wt_q, rd_cnt_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt_q <= '0;
            fv_q     <= 1'b0;
            frow_q   <= '0;
        end else begin
            fv_q   <= rd_en;
            frow_q <= rd_cnt_q;
            if (rd_en) begin
                rd_cnt_q <= rd_cnt_q + 2'd1;
            end else if (state_q != ST_FEED) begin
                rd_cnt_q <= '0;
            end
        end
    end

    // Rows beyond n are forced to zero
    assign row_live    = ({1'b0, frow_q} < n_cur);
    assign feed.valid  = fv_q;
    assign feed.first  = fv_q && (frow_q == 2'd0);
    assign feed.x_row  = row_live ? i_in_rd_row : '0;
    assign feed.w_row  = row_live ? i_wt_rd_row : '0;

    // --------------------
    // Output window
    // --------------------

    assign fire_first = feed.valid && feed.ready && feed.first;

    // Cycles since row 0 was accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcnt_q <= '0;
        end else if (state_q != ST_FEED && state_q != ST_DRAIN) begin
            dcnt_q <= '0;
        end else if (fire_first || dcnt_q != 4'd0) begin
            dcnt_q <= dcnt_q + 4'd1;
        end
    end

    // Sum k shows up LANES + k cycles after row 0, for k up to 2n-2
    assign win_last = 4'(LANES) + {n_cur, 1'b0} - 4'd2;
    assign in_win   = (dcnt_q >= 4'(LANES)) && (dcnt_q <= win_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_out_valid <= 1'b0;
            o_out_value <= '0;
        end else begin
            o_out_valid <= in_win;
            o_out_value <= in_win ? i_diag_sum : '0;
        end
    end

endmodule

//--- logic/pe.sv
`timescale 1ns/100ps

module pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_load_w,
    input  mmsa_pkg::acc_t  i_a,
    input  mmsa_pkg::acc_t  i_b,
    input  mmsa_pkg::elem_t i_w,
    output mmsa_pkg::acc_t  o_c,
    output mmsa_pkg::acc_t  o_d
);
    import mmsa_pkg::*;

    elem_t w_q;
    elem_t w_use;

    // New weight takes effect in the cycle it is loaded
    assign w_use = i_load_w ? i_w : w_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_q <= '0;
        end else if (i_load_w) begin
            w_q <= i_w;
        end
    end

    // Partial sum goes down and input goes right
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_c <= '0;
            o_d <= '0;
        end else begin
            o_c <= i_a * w_use + i_b;
            o_d <= i_a;
        end
    end

endmodule

//--- logic/systolic_array.sv
`timescale 1ns/100ps

module systolic_array (
    input  logic           clk,
    input  logic           rst_n,
    array_feed_if.array    feed,
    output mmsa_pkg::acc_t o_diag_sum
);
    import mmsa_pkg::*;

    logic             fire;
    logic             busy_q;
    logic [3:0]       age_q;
    logic [LANES-1:1] load_d_q;
    logic [LANES-1:0] load_w;
    acc_t             hin  [LANES][LANES];
    acc_t             vsum [LANES+1][LANES];

    assign fire   = feed.valid && feed.ready;
    assign load_w = {load_d_q, fire && feed.first};

    // --------------------
    // Drain tracking
    // --------------------

    // Open for rows 1 to 3, then closed until the last sum of the pair
    // has left the bottom row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            age_q  <= '0;
        end else if (fire && feed.first) begin
            busy_q <= 1'b1;
            age_q  <= 4'd1;
        end else if (busy_q) begin
            age_q <= age_q + 4'd1;
            if (age_q == 4'(3 * LANES - 2)) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign feed.ready = !busy_q || (age_q < 4'(LANES));

    // Weight strobe walks down one PE row per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_d_q <= '0;
        end else begin
            load_d_q <= load_w[LANES-2:0];
        end
    end

    // --------------------
    // PE grid
    // --------------------

    for (genvar c = 0; c < LANES; c++) begin : g_top
        assign vsum[0][c] = '0;
    end

    for (genvar r = 0; r < LANES; r++) begin : g_row
        elem_t x_lane;

        assign x_lane = fire ? feed.x_row[r] : '0;

        // Lane r reaches PE row r after r cycles
        if (r == 0) begin : g_direct
            assign hin[r][0] = acc_t'(x_lane);
        end else begin : g_skew
            elem_t skew_q [r];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < r; s++) begin
                        skew_q[s] <= '0;
                    end
                end else begin
                    skew_q[0] <= x_lane;
                    for (int s = 1; s < r; s++) begin
                        skew_q[s] <= skew_q[s-1];
                    end
                end
            end

            assign hin[r][0] = acc_t'(skew_q[r-1]);
        end

        for (genvar c = 0; c < LANES; c++) begin : g_col
            if (c < LANES - 1) begin : g_pass
                pe u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .i_load_w (load_w[r]),
                    .i_a      (hin[r][c]),
                    .i_b      (vsum[r][c]),
                    .i_w      (feed.w_row[c]),
                    .o_c      (vsum[r+1][c]),
                    .o_d      (hin[r][c+1])
                );
            end else begin : g_edge
                // Rightmost column has no neighbour to pass to
                pe u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .i_load_w (load_w[r]),
                    .i_a      (hin[r][c]),
                    .i_b      (vsum[r][c]),
                    .i_w      (feed.w_row[c]),
                    .o_c      (vsum[r+1][c]),
                    .o_d      ()
                );
            end
        end
    end

    // Bottom row sum gives one anti-diagonal per cycle
    always_comb begin
        o_diag_sum = '0;
        for (int c = 0; c < LANES; c++) begin
            o_diag_sum = o_diag_sum + vsum[LANES][c];
        end
    end

endmodule

//--- logic/mmsa.sv
`timescale 1ns/100ps

module mmsa (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_in_valid,
    input  mmsa_pkg::elem_t                i_matrix,
    input  mmsa_pkg::mat_size_e            i_matrix_size,
    input  logic                           i_in_valid2,
    input  logic [mmsa_pkg::MAT_IDX_W-1:0] i_i_mat_idx,
    input  logic [mmsa_pkg::MAT_IDX_W-1:0] i_w_mat_idx,
    output logic                           o_out_valid,
    output mmsa_pkg::acc_t                 o_out_value
);
    import mmsa_pkg::*;

    logic                   in_wr_en;
    logic                   wt_wr_en;
    logic [BANK_ADDR_W-1:0] wr_addr;
    row_t                   wr_row;
    logic [BANK_ADDR_W-1:0] in_rd_addr;
    logic [BANK_ADDR_W-1:0] wt_rd_addr;
    row_t                   in_rd_row;
    row_t                   wt_rd_row;
    acc_t                   diag_sum;

    array_feed_if feed_if ();

    // Input matrices
    matrix_bank u_in_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_en   (in_wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_row  (wr_row),
        .i_rd_addr (in_rd_addr),
        .o_rd_row  (in_rd_row)
    );

    // Weight matrices
    matrix_bank u_wt_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_en   (wt_wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_row  (wr_row),
        .i_rd_addr (wt_rd_addr),
        .o_rd_row  (wt_rd_row)
    );

    mmsa_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_in_valid    (i_in_valid),
        .i_matrix      (i_matrix),
        .i_matrix_size (i_matrix_size),
        .i_in_valid2   (i_in_valid2),
        .i_i_mat_idx   (i_i_mat_idx),
        .i_w_mat_idx   (i_w_mat_idx),
        .o_in_wr_en    (in_wr_en),
        .o_wt_wr_en    (wt_wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_row      (wr_row),
        .o_in_rd_addr  (in_rd_addr),
        .o_wt_rd_addr  (wt_rd_addr),
        .i_in_rd_row   (in_rd_row),
        .i_wt_rd_row   (wt_rd_row),
        .feed          (feed_if),
        .i_diag_sum    (diag_sum),
        .o_out_valid   (o_out_valid),
        .o_out_value   (o_out_value)
    );

    systolic_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed       (feed_if),
        .o_diag_sum (diag_sum)
    );

endmodule

//--- verif/mmsa_sva.sv
`timescale 1ns/100ps

module mmsa_sva (
    input logic           clk,
    input logic           rst_n,
    input logic           i_out_valid,
    input mmsa_pkg::acc_t i_out_value
);
    import mmsa_pkg::*;

    logic [4:0] run_q;

    // Length of the valid burst seen so far
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= '0;
        end else if (i_out_valid) begin
            run_q <= run_q + 5'd1;
        end else begin
            run_q <= '0;
        end
    end

    // --------------------
    // Output protocol
    // --------------------

    quiet_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !i_out_valid |-> i_out_value == '0)
    else begin
        mmsa_tb.sva_err_cnt++;
        $error("Error at %0t: o_out_value expected 0 got %0d", $time, $sampled(i_out_value));
    end

    burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_out_valid) |-> run_q == mmsa_tb.exp_len)
    else begin
        mmsa_tb.sva_err_cnt++;
        $error("Error at %0t: o_out_valid burst length expected %0d got %0d",
               $time, $sampled(mmsa_tb.exp_len), $sampled(run_q));
    end

    // --------------------
    // Values
    // --------------------

    no_stray: assert property (@(posedge clk) disable iff (!rst_n)
        i_out_valid |-> mmsa_tb.exp_live)
    else begin
        mmsa_tb.sva_err_cnt++;
        $error("Output valid at %0t while no result was pending", $time);
    end

    value_ok: assert property (@(posedge clk) disable iff (!rst_n)
        i_out_valid && mmsa_tb.exp_live |-> i_out_value == mmsa_tb.exp_cur)
    else begin
        mmsa_tb.sva_err_cnt++;
        $error("Error at %0t: o_out_value expected %0d got %0d",
               $time, $sampled(mmsa_tb.exp_cur), $sampled(i_out_value));
    end

endmodule

//--- verif/mmsa_tb.sv
`timescale 1ns/100ps

module mmsa_tb;
    import mmsa_pkg::*;

    localparam int LOAD_2 = 2 * NUM_MATS * 4;
    localparam int LOAD_4 = 2 * NUM_MATS * 16;
    localparam int PAIR_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = 2 * (LOAD_2 + LOAD_4 + 2 * NUM_PAIRS * PAIR_CYCLES);
    localparam int TOTAL_OUTPUTS = NUM_PAIRS * (3 + 7);
    localparam logic [31:0] SEED = 32'd87014;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    elem_t                matrix;
    mat_size_e            matrix_size;
    logic                 in_valid2;
    logic [MAT_IDX_W-1:0] i_mat_idx;
    logic [MAT_IDX_W-1:0] w_mat_idx;
    logic                 out_valid;
    acc_t                 out_value;

    logic [31:0]          rng_state;
    elem_t                x_mats [NUM_MATS][4][4];
    elem_t                w_mats [NUM_MATS][4][4];
    logic [MAT_IDX_W-1:0] pair_x [NUM_PAIRS];
    logic [MAT_IDX_W-1:0] pair_w [NUM_PAIRS];
    acc_t                 exp_q [$];

    // Read by the bound assertions
    acc_t exp_cur;
    logic exp_live;
    int   exp_len;
    int   sva_err_cnt;
    int   tb_err_cnt;
    int   outputs_seen;
    int   cycle_cnt;

    mmsa mmsa_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_in_valid    (in_valid),
        .i_matrix      (matrix),
        .i_matrix_size (matrix_size),
        .i_in_valid2   (in_valid2),
        .i_i_mat_idx   (i_mat_idx),
        .i_w_mat_idx   (w_mat_idx),
        .o_out_valid   (out_valid),
        .o_out_value   (out_value)
    );

    bind mmsa mmsa_sva u_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_out_valid (o_out_valid),
        .i_out_value (o_out_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_word(output logic [31:0] w);
        rng_state = xorshift32(rng_state);
        w = rng_state;
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #0.5;
    endtask

    // Random contents with matrices 0 and 15 pinned to the signed extremes
    task automatic fill_matrices(input int n);
        logic [31:0] w;
        for (int m = 0; m < NUM_MATS; m++) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    x_mats[m][r][c] = '0;
                    w_mats[m][r][c] = '0;
                    if (r < n && c < n) begin
                        draw_word(w);
                        x_mats[m][r][c] = elem_t'(w[15:0]);
                        w_mats[m][r][c] = elem_t'(w[31:16]);
                        if (m == 0) begin
                            x_mats[m][r][c] = elem_t'(32767);
                            w_mats[m][r][c] = elem_t'(32767);
                        end else if (m == 15) begin
                            x_mats[m][r][c] = elem_t'(-32768);
                            w_mats[m][r][c] = elem_t'(-32768);
                        end
                    end
                end
            end
        end
    endtask

    // Repeats and extreme indices come before the random pairs
    task automatic choose_pairs();
        logic [31:0] w;
        pair_x[0] = 4'd0;
        pair_w[0] = 4'd0;
        pair_x[1] = 4'd15;
        pair_w[1] = 4'd15;
        pair_x[2] = 4'd15;
        pair_w[2] = 4'd15;
        pair_x[3] = 4'd0;
        pair_w[3] = 4'd15;
        pair_x[4] = 4'd15;
        pair_w[4] = 4'd0;
        for (int p = 5; p < NUM_PAIRS; p++) begin
            draw_word(w);
            pair_x[p] = w[3:0];
            pair_w[p] = w[7:4];
        end
    endtask

    // Row-major stream of all input matrices followed by all weights
    task automatic load_matrices(input int n, input mat_size_e size);
        next_drive_point();
        matrix_size = size;
        in_valid    = 1'b1;
        for (int kind = 0; kind < 2; kind++) begin
            for (int m = 0; m < NUM_MATS; m++) begin
                for (int r = 0; r < n; r++) begin
                    for (int c = 0; c < n; c++) begin
                        matrix = (kind == 0) ? x_mats[m][r][c] : w_mats[m][r][c];
                        next_drive_point();
                    end
                end
            end
        end
        in_valid = 1'b0;
        matrix   = '0;
    endtask

    // Anti-diagonal sums of X times W
    task automatic push_expected(input int xi, input int wi, input int n);
        longint p [4][4];
        longint s;
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                p[r][c] = 0;
                for (int j = 0; j < n; j++) begin
                    p[r][c] += longint'(x_mats[xi][r][j]) * longint'(w_mats[wi][j][c]);
                end
            end
        end
        for (int k = 0; k <= 2 * n - 2; k++) begin
            s = 0;
            for (int r = 0; r < n; r++) begin
                if (k - r >= 0 && k - r < n) begin
                    s += p[r][k-r];
                end
            end
            exp_q.push_back(acc_t'(s));
        end
    endtask

    task automatic run_pair(input logic [3:0] xi, input logic [3:0] wi, input int n);
        next_drive_point();
        i_mat_idx = xi;
        w_mat_idx = wi;
        in_valid2 = 1'b1;
        next_drive_point();
        in_valid2 = 1'b0;
        // Results become due once the pair has been accepted
        push_expected(xi, wi, n);
        // Burst start, then burst end
        do @(negedge clk); while (!out_valid);
        do @(negedge clk); while (out_valid);
    endtask

    task automatic run_size(input mat_size_e size);
        int n;
        n = (size == SIZE_4) ? 4 : 2;
        exp_len = 2 * n - 1;
        fill_matrices(n);
        choose_pairs();
        load_matrices(n, size);
        repeat (3) next_drive_point();
        for (int p = 0; p < NUM_PAIRS; p++) begin
            run_pair(pair_x[p], pair_w[p], n);
        end
        repeat (8) next_drive_point();
    endtask

    // --------------------
    // Output tracking
    // --------------------

    // One expected value taken per valid output, between clock edges
    always @(negedge clk) begin
        if (out_valid) begin
            outputs_seen++;
            exp_live = (exp_q.size() > 0);
            if (exp_live) begin
                exp_cur = exp_q.pop_front();
            end else begin
                exp_cur = '0;
            end
        end else begin
            exp_live = 1'b0;
            exp_cur  = '0;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles without finishing: %0d assertion errors",
                 cycle_cnt, sva_err_cnt);
        $display("Something failed");
        $finish;
    end

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        matrix       = '0;
        matrix_size  = SIZE_2;
        in_valid2    = 1'b0;
        i_mat_idx    = '0;
        w_mat_idx    = '0;
        exp_cur      = '0;
        exp_live     = 1'b0;
        exp_len      = 3;
        sva_err_cnt  = 0;
        tb_err_cnt   = 0;
        outputs_seen = 0;
        rng_state    = SEED;

        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        repeat (4) next_drive_point();

        run_size(SIZE_2);
        run_size(SIZE_4);

        assert (exp_q.size() == 0) else begin
            tb_err_cnt++;
            $display("%0d expected results were never produced", exp_q.size());
        end
        assert (outputs_seen == TOTAL_OUTPUTS) else begin
            tb_err_cnt++;
            $display("Saw %0d valid outputs where %0d were due", outputs_seen, TOTAL_OUTPUTS);
        end

        $display("Checked %0d outputs: %0d assertion errors, %0d other errors",
                 outputs_seen, sva_err_cnt, tb_err_cnt);
        if (sva_err_cnt + tb_err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- mmsa.f
logic/mmsa_pkg.sv
logic/array_feed_if.sv
logic/matrix_bank.sv
logic/mmsa_ctrl.sv
logic/pe.sv
logic/systolic_array.sv
logic/mmsa.sv
verif/mmsa_sva.sv
verif/mmsa_tb.sv

//--- Bender.yml
package:
  name: mmsa

sources:
  - files:
      - logic/mmsa_pkg.sv
      - logic/array_feed_if.sv
      - logic/matrix_bank.sv
      - logic/mmsa_ctrl.sv
      - logic/pe.sv
      - logic/systolic_array.sv
      - logic/mmsa.sv
  - target: test
    files:
      - verif/mmsa_sva.sv
      - verif/mmsa_tb.sv
